// File: bitsync.f
+incdir+.
logic/bitsyncPkg.sv
logic/bitsyncRegPkg.sv
logic/sampleSummer.sv
logic/timingErrorDetector.sv
logic/lockDetector.sv
logic/loopFilter.sv
logic/bitsyncRegs.sv
logic/bitsync.sv
dv/bitsync_props.sv
dv/bitsyncTb.sv

// File: bitsync_defs.svh
// Bit synchronizer widths and defaults
`ifndef BITSYNC_DEFS_SVH
`define BITSYNC_DEFS_SVH

// Datapath widths
`define SAMPLE_WIDTH        18
`define ERROR_WIDTH         12
`define FREQ_WIDTH          32
`define LOCK_WIDTH          16

// Averaging window, transitions minus one
`define AVG_COUNT           15
`define AVG_WIDTH           22

`define REG_ADDR_WIDTH      4

// Register reset values
`define DEFAULT_LOCK_COUNT  4
`define DEFAULT_PROP_SHIFT  8
`define DEFAULT_INT_SHIFT   16

`endif

// File: dv/bitsyncTb.sv
// Bit synchronizer testbench
`timescale 1ns/1ps
`include "bitsync_defs.svh"

module bitsyncTb import bitsyncPkg::*, bitsyncRegPkg::*; ();

    localparam sampleT level = sampleT'(18'h10000);
    localparam int totalSymbols = 2700;
    localparam int checkWindow = 32;

    logic clk = 1'b0;
    logic reset;
    logic sym2xEn;
    sampleT i;
    sampleT q;
    logic regWrite;
    regAddrT regAddr;
    regDataT regWdata;
    regDataT regRdata;
    freqT sampleFreq;
    logic iSymEn;
    logic qSymEn;
    logic bitDataI;
    logic bitDataQ;
    sampleT symDataI;
    sampleT symDataQ;
    logic bitsyncLock;
    lockCountT lockCounter;

    logic [31:0] lfsr = 32'h6be9;
    logic enCap = 1'b0;
    logic symCap = 1'b0;
    logic qCap = 1'b0;
    bit recI[$];
    bit recQ[$];
    sampleT symI[$];
    sampleT symQ[$];
    bit holdCheck = 1'b0;
    freqT holdFreq;
    bit lockSeen;
    bit slipSeen;
    int enSinceSlip;
    int lockEnables;
    int errors = 0;
    int testErrors;
    int testsRun = 0;
    int testsFailed = 0;

    always #50 clk = ~clk;

    bitsync dut0 (
        .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .i(i), .q(q),
        .regWrite(regWrite), .regAddr(regAddr), .regWdata(regWdata),
        .regRdata(regRdata), .sampleFreq(sampleFreq), .iSymEn(iSymEn),
        .qSymEn(qSymEn), .bitDataI(bitDataI), .bitDataQ(bitDataQ),
        .symDataI(symDataI), .symDataQ(symDataQ), .bitsyncLock(bitsyncLock),
        .lockCounter(lockCounter)
    );

    //**************************************************
    // Reference model
    //**************************************************
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // Sent bit of symbol k, replayed from the LFSR state at stream start
    function automatic bit refSymbolBit(input logic [31:0] s, input int k, input bit qRail);
        int n;
        for (n = 0; n < 2 * k + qRail; n++) begin
            s = lfsrNext(s);
        end
        return s[0];
    endfunction

    // Middle sample of symbol k, the summer halves it next to a zero off-time sample
    function automatic sampleT expectedSample(input logic [31:0] s, input int k,
                                              input bit qRail, input bit summer);
        sampleT cur;
        sampleT prev;
        cur = refSymbolBit(s, k, qRail) ? -level : level;
        prev = level;
        if (k > 0) begin
            prev = refSymbolBit(s, k - 1, qRail) ? -level : level;
        end
        if (summer && prev != cur) begin
            return cur >>> 1;
        end
        return cur;
    endfunction

    function automatic regDataT refReadback(input regAddrT a, input regDataT w,
                                            input freqT center);
        case (a)
            ctrlAddr:       return w & 32'h1;
            centerFreqAddr: return w;
            gainAddr:       return w & 32'h1f1f;
            lockCountAddr:  return w & 32'hffff;
            sampleFreqAddr: return center;
            default:        return '0;
        endcase
    endfunction

    // Off-time sample between two symbols, bias follows the transition
    function automatic sampleT offSample(input sampleT prev, input sampleT cur, input int bias);
        if (prev == cur) begin
            return cur;
        end
        return (cur > prev) ? sampleT'(bias) : sampleT'(-bias);
    endfunction

    //**************************************************
    // Monitor and comparison process
    //**************************************************
    always @(posedge clk) begin
        enCap  <= sym2xEn;
        symCap <= iSymEn;
        qCap   <= qSymEn;
    end

    always @(negedge clk) begin
        if (symCap) begin
            recI.push_back(bitDataI);
            symI.push_back(symDataI);
        end
        if (qCap) begin
            recQ.push_back(bitDataQ);
            symQ.push_back(symDataQ);
        end
        if (enCap) begin
            enSinceSlip++;
        end
        if (dut0.slip) begin
            enSinceSlip = 0;
            slipSeen = 1'b1;
        end
        if (bitsyncLock && !lockSeen) begin
            lockSeen = 1'b1;
            lockEnables = enSinceSlip;
            // Declaring lock clears the counter
            assert (lockCounter == '0) else begin
                $display("MISMATCH lockCounter got %h expected %h", lockCounter, 16'h0);
                errors++;
            end
        end
        if (holdCheck) begin
            assert (sampleFreq == holdFreq) else begin
                $display("MISMATCH sampleFreq got %h expected %h", sampleFreq, holdFreq);
                errors++;
            end
        end
    end

    //**************************************************
    // Bus and stimulus tasks
    //**************************************************
    task automatic resetDut();
        @(negedge clk);
        reset = 1'b1;
        sym2xEn = 1'b0;
        regWrite = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        recI.delete();
        recQ.delete();
        symI.delete();
        symQ.delete();
        lockSeen = 1'b0;
        slipSeen = 1'b0;
        enSinceSlip = 0;
    endtask

    task automatic writeReg(input regAddrT a, input regDataT w);
        @(negedge clk);
        regWrite = 1'b1;
        regAddr = a;
        regWdata = w;
        @(negedge clk);
        regWrite = 1'b0;
    endtask

    task automatic checkRead(input regAddrT a, input regDataT expected);
        @(negedge clk);
        regAddr = a;
        #10;
        assert (regRdata == expected) else begin
            $display("MISMATCH regRdata addr %h got %h expected %h", a, regRdata, expected);
            errors++;
        end
    endtask

    task automatic configure(input regDataT ctrl, input freqT center, input regDataT gain,
                             input regDataT lockCnt);
        writeReg(ctrlAddr, ctrl);
        writeReg(centerFreqAddr, center);
        writeReg(gainAddr, gain);
        writeReg(lockCountAddr, lockCnt);
    endtask

    task automatic sendSample(input sampleT a, input sampleT b);
        @(negedge clk);
        sym2xEn = 1'b1;
        i = a;
        q = b;
        @(negedge clk);
        sym2xEn = 1'b0;
    endtask

    // Two samples per symbol, an extra lead sample shifts the phase
    task automatic streamSymbols(input int nSym, input bit misalign, input int bias,
                                 output logic [31:0] startState);
        sampleT prevI;
        sampleT prevQ;
        sampleT curI;
        sampleT curQ;
        int k;
        startState = lfsr;
        prevI = level;
        prevQ = level;
        if (misalign) begin
            sendSample(level, level);
        end
        for (k = 0; k < nSym; k++) begin
            curI = lfsr[0] ? -level : level;
            lfsr = lfsrNext(lfsr);
            curQ = lfsr[0] ? -level : level;
            lfsr = lfsrNext(lfsr);
            sendSample(offSample(prevI, curI, bias), offSample(prevQ, curQ, bias));
            sendSample(curI, curQ);
            prevI = curI;
            prevQ = curQ;
        end
        repeat (4) @(negedge clk);
    endtask

    // Last recovered bits against the sent ones, lag 2 plus up to two slips
    task automatic checkBits(input logic [31:0] startState, input int nSym, input bit summer);
        int lag;
        int r;
        int k;
        int bad;
        bit found;
        found = 1'b0;
        assert (recQ.size() == recI.size()) else begin
            $display("qSymEn gave %0d symbols where iSymEn gave %0d",
                     recQ.size(), recI.size());
            errors++;
        end
        for (lag = 2; lag <= 4 && !found && recQ.size() == recI.size(); lag++) begin
            bad = 0;
            for (r = recI.size() - checkWindow; r < recI.size(); r++) begin
                k = r - lag;
                if (r < 0 || k < 0 || k >= nSym) begin
                    bad++;
                end else if (recI[r] != refSymbolBit(startState, k, 1'b0) ||
                             recQ[r] != refSymbolBit(startState, k, 1'b1) ||
                             symI[r] != expectedSample(startState, k, 1'b0, summer) ||
                             symQ[r] != expectedSample(startState, k, 1'b1, summer)) begin
                    bad++;
                end
            end
            found = (bad == 0);
        end
        assert (found) else begin
            k = recI.size() - 3;
            $display("MISMATCH bitDataI/bitDataQ/symDataI got %h/%h/%h expected %h/%h/%h",
                     recI[$], recQ[$], symI[$], refSymbolBit(startState, k, 1'b0),
                     refSymbolBit(startState, k, 1'b1),
                     expectedSample(startState, k, 1'b0, summer));
            errors++;
        end
    endtask

    task automatic startTest();
        testErrors = errors;
    endtask

    task automatic endTest(input int num, input string name);
        testsRun++;
        if (errors == testErrors) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: fail", num, name);
        end
    endtask

    //**************************************************
    // Watchdog
    //**************************************************
    initial begin
        #(2 * (totalSymbols * 4 + 400) * 100);
        $display("Watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    //**************************************************
    // Test sequence
    //**************************************************
    initial begin
        logic [31:0] st;
        reset = 1'b1;
        sym2xEn = 1'b0;
        i = '0;
        q = '0;
        regWrite = 1'b0;
        regAddr = '0;
        regWdata = '0;

        startTest();
        resetDut();
        writeReg(ctrlAddr, 32'hffff_fff1);
        checkRead(ctrlAddr, refReadback(ctrlAddr, 32'hffff_fff1, '0));
        writeReg(centerFreqAddr, 32'ha5c3_0f96);
        checkRead(centerFreqAddr, refReadback(centerFreqAddr, 32'ha5c3_0f96, '0));
        writeReg(gainAddr, 32'h55aa_ea6b);
        checkRead(gainAddr, refReadback(gainAddr, 32'h55aa_ea6b, '0));
        writeReg(lockCountAddr, 32'h1234_0007);
        checkRead(lockCountAddr, refReadback(lockCountAddr, 32'h1234_0007, '0));
        writeReg(statusAddr, 32'hffff_ffff);
        checkRead(statusAddr, refReadback(statusAddr, 32'hffff_ffff, '0));
        writeReg(sampleFreqAddr, 32'hffff_ffff);
        checkRead(sampleFreqAddr, refReadback(sampleFreqAddr, 32'hffff_ffff, 32'ha5c3_0f96));
        checkRead(regAddrT'(7), '0);
        endTest(1, "register readback");

        startTest();
        resetDut();
        configure(0, 32'h1234_5678, 32'h1f1f, `DEFAULT_LOCK_COUNT);
        holdFreq = 32'h1234_5678;
        holdCheck = 1'b1;
        streamSymbols(300, 1'b0, 32'h400, st);
        holdCheck = 1'b0;
        endTest(2, "loop paths off");

        startTest();
        resetDut();
        configure(0, 0, 32'h1008, `DEFAULT_LOCK_COUNT);
        streamSymbols(300, 1'b0, 0, st);
        checkBits(st, 300, 1'b0);
        endTest(3, "clean bypass bits");

        startTest();
        resetDut();
        configure(0, 32'h4000_0000, 32'h081f, `DEFAULT_LOCK_COUNT);
        streamSymbols(300, 1'b0, 32'h400, st);
        assert (sampleFreq > 32'h4000_0000) else begin
            $display("sampleFreq %h did not rise above centerFreq with positive bias",
                     sampleFreq);
            errors++;
        end
        resetDut();
        configure(0, 32'h4000_0000, 32'h081f, `DEFAULT_LOCK_COUNT);
        streamSymbols(300, 1'b0, -32'sh400, st);
        assert (sampleFreq < 32'h4000_0000) else begin
            $display("sampleFreq %h did not fall below centerFreq with negative bias",
                     sampleFreq);
            errors++;
        end
        endTest(4, "loop direction");

        startTest();
        resetDut();
        configure(0, 0, 32'h1008, 1);
        streamSymbols(1200, 1'b1, 0, st);
        checkBits(st, 1200, 1'b0);
        assert (slipSeen && lockSeen && lockEnables <= (1 + 2) * 16 * 4) else begin
            $display("No slip, or bitsyncLock late after it (slip %0d lock %0d after %0d)",
                     slipSeen, lockSeen, lockEnables);
            errors++;
        end
        endTest(5, "slip and lock");

        startTest();
        resetDut();
        configure(1, 0, 32'h1008, `DEFAULT_LOCK_COUNT);
        streamSymbols(300, 1'b0, 0, st);
        checkBits(st, 300, 1'b1);
        endTest(6, "summer bits");

        $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: dv/bitsync_props.sv
// Bit synchronizer port assertions
`timescale 1ns/1ps

module bitsyncProps (
    input logic clk,
    input logic reset,
    input logic sym2xEn,
    input logic iSymEn,
    input logic bitsyncLock
);

    logic symEnLast;
    logic symEnPrev;

    // iSymEn seen on the last two enables
    always_ff @(posedge clk) begin
        if (reset) begin
            symEnLast <= 1'b0;
            symEnPrev <= 1'b0;
        end else if (sym2xEn) begin
            symEnLast <= iSymEn;
            symEnPrev <= symEnLast;
        end
    end

    symEnOnEnable: assert property (@(posedge clk) disable iff (reset) iSymEn |-> sym2xEn)
        else $error("iSymEn high without sym2xEn");

    lockLowInReset: assert property (@(posedge clk) reset && $past(reset) |-> !bitsyncLock)
        else $error("bitsyncLock high during reset");

    // A slip hold gives two symbol enables in a row, never three
    noTripleSymEn: assert property (@(posedge clk) disable iff (reset)
        sym2xEn && symEnLast && symEnPrev |-> !iSymEn)
        else $error("iSymEn on three consecutive enables");

endmodule

bind bitsync bitsyncProps props0 (
    .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .iSymEn(iSymEn),
    .bitsyncLock(bitsyncLock)
);

// File: logic/bitsync.sv
// Bit synchronizer top level
`timescale 1ns/1ps

module bitsync import bitsyncPkg::*, bitsyncRegPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      sym2xEn,
    input  sampleT    i,
    input  sampleT    q,
    input  logic      regWrite,
    input  regAddrT   regAddr,
    input  regDataT   regWdata,
    output regDataT   regRdata,
    output freqT      sampleFreq,
    output logic      iSymEn,
    output logic      qSymEn,
    output logic      bitDataI,
    output logic      bitDataQ,
    output sampleT    symDataI,
    output sampleT    symDataQ,
    output logic      bitsyncLock,
    output lockCountT lockCounter
);

    sampleT     filtI;
    sampleT     filtQ;
    wideErrorT  timingError;
    sampleT     absError;
    sampleT     absSlipError;
    logic       errorEn;
    logic       transition;
    logic       slip;
    logic       useSummer;
    freqT       centerFreq;
    logic [4:0] propShift;
    logic [4:0] intShift;
    lockCountT  lockCount;

    // Both rails share one symbol timing
    assign iSymEn = errorEn;
    assign qSymEn = errorEn;

    sampleSummer summer0 (
        .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .useSummer(useSummer),
        .i(i), .q(q), .filtI(filtI), .filtQ(filtQ)
    );

    timingErrorDetector ted0 (
        .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .slip(slip),
        .filtI(filtI), .filtQ(filtQ), .errorEn(errorEn), .transition(transition),
        .bitDataI(bitDataI), .bitDataQ(bitDataQ), .timingError(timingError),
        .absError(absError), .absSlipError(absSlipError),
        .symDataI(symDataI), .symDataQ(symDataQ)
    );

    lockDetector lock0 (
        .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .errorEn(errorEn),
        .transition(transition), .absError(absError), .absSlipError(absSlipError),
        .lockCount(lockCount), .slip(slip), .bitsyncLock(bitsyncLock),
        .lockCounter(lockCounter)
    );

    loopFilter loop0 (
        .clk(clk), .reset(reset), .errorEn(errorEn), .timingError(timingError),
        .centerFreq(centerFreq), .propShift(propShift), .intShift(intShift),
        .sampleFreq(sampleFreq)
    );

    bitsyncRegs regs0 (
        .clk(clk), .reset(reset), .regWrite(regWrite), .regAddr(regAddr),
        .regWdata(regWdata), .bitsyncLock(bitsyncLock), .lockCounter(lockCounter),
        .sampleFreq(sampleFreq), .regRdata(regRdata), .useSummer(useSummer),
        .centerFreq(centerFreq), .propShift(propShift), .intShift(intShift),
        .lockCount(lockCount)
    );

endmodule

// File: logic/bitsyncPkg.sv
// Bit synchronizer datapath types
`include "bitsync_defs.svh"

package bitsyncPkg;

    // Baseband and loop quantities
    typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;
    typedef logic signed [`SAMPLE_WIDTH:0]   wideErrorT;
    typedef logic signed [`AVG_WIDTH-1:0]    avgT;
    typedef logic [`FREQ_WIDTH-1:0]          freqT;
    typedef logic [`LOCK_WIDTH-1:0]          lockCountT;

    // Gain shift code that switches a loop path off
    localparam logic [4:0] shiftOff = 5'd31;

    typedef enum logic {
        onTime  = 1'b0,
        offTime = 1'b1
    } tedStateT;

    // Gray ordered so each step flips one bit
    typedef enum logic [1:0] {
        average = 2'b00,
        test    = 2'b01,
        slip0   = 2'b11,
        slip1   = 2'b10
    } slipStateT;

endpackage

// File: logic/bitsyncRegPkg.sv
// Bit synchronizer register map
`include "bitsync_defs.svh"

package bitsyncRegPkg;

    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;
    typedef logic [31:0]                regDataT;

    // Word addresses on the register bus
    typedef enum regAddrT {
        ctrlAddr       = regAddrT'(0),
        centerFreqAddr = regAddrT'(1),
        gainAddr       = regAddrT'(2),
        lockCountAddr  = regAddrT'(3),
        // Read only from here on
        statusAddr     = regAddrT'(4),
        sampleFreqAddr = regAddrT'(5)
    } regAddrE;

endpackage

// File: logic/bitsyncRegs.sv
// Bit synchronizer register bank
`timescale 1ns/1ps
`include "bitsync_defs.svh"

module bitsyncRegs import bitsyncPkg::*, bitsyncRegPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       regWrite,
    input  regAddrT    regAddr,
    input  regDataT    regWdata,
    input  logic       bitsyncLock,
    input  lockCountT  lockCounter,
    input  freqT       sampleFreq,
    output regDataT    regRdata,
    output logic       useSummer,
    output freqT       centerFreq,
    output logic [4:0] propShift,
    output logic [4:0] intShift,
    output lockCountT  lockCount
);

    //**************************************************
    // Write decode
    //**************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            useSummer  <= 1'b0;
            centerFreq <= '0;
            propShift  <= 5'(`DEFAULT_PROP_SHIFT);
            intShift   <= 5'(`DEFAULT_INT_SHIFT);
            lockCount  <= lockCountT'(`DEFAULT_LOCK_COUNT);
        end else if (regWrite) begin
            case (regAddr)
                ctrlAddr:       useSummer <= regWdata[0];
                centerFreqAddr: centerFreq <= freqT'(regWdata);
                gainAddr: begin
                    propShift <= regWdata[4:0];
                    intShift  <= regWdata[12:8];
                end
                lockCountAddr:  lockCount <= lockCountT'(regWdata);
                // Status words are read only
                default: ;
            endcase
        end
    end

    // Readback mux
    always_comb begin
        case (regAddr)
            ctrlAddr:       regRdata = {31'b0, useSummer};
            centerFreqAddr: regRdata = regDataT'(centerFreq);
            gainAddr:       regRdata = {19'b0, intShift, 3'b0, propShift};
            lockCountAddr:  regRdata = regDataT'(lockCount);
            statusAddr:     regRdata = {15'b0, bitsyncLock, lockCounter};
            sampleFreqAddr: regRdata = regDataT'(sampleFreq);
            default:        regRdata = '0;
        endcase
    end

endmodule

// File: logic/lockDetector.sv
// Averaging, slip and lock detection
`timescale 1ns/1ps
`include "bitsync_defs.svh"

module lockDetector import bitsyncPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      sym2xEn,
    input  logic      errorEn,
    input  logic      transition,
    input  sampleT    absError,
    input  sampleT    absSlipError,
    input  lockCountT lockCount,
    output logic      slip,
    output logic      bitsyncLock,
    output lockCountT lockCounter
);

    localparam int avgCountWidth = $clog2(`AVG_COUNT + 1);

    slipStateT                slipState;
    logic [avgCountWidth-1:0] avgCount;
    avgT                      avgError;
    avgT                      avgSlipError;
    logic                     slipLow;

    // Off-phase sampling puts the slip samples near zero
    assign slipLow = avgSlipError < (avgError >>> 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            slipState    <= average;
            avgCount     <= avgCountWidth'(`AVG_COUNT);
            avgError     <= '0;
            avgSlipError <= '0;
        end else if (sym2xEn) begin
            case (slipState)
                average: begin
                    if (errorEn && transition) begin
                        avgError     <= avgError + avgT'(absError);
                        avgSlipError <= avgSlipError + avgT'(absSlipError);
                        if (avgCount == 0) begin
                            slipState <= test;
                        end else begin
                            avgCount <= avgCount - 1'b1;
                        end
                    end
                end
                test: begin
                    avgCount     <= avgCountWidth'(`AVG_COUNT);
                    avgError     <= '0;
                    avgSlipError <= '0;
                    slipState    <= slip0;
                end
                slip0:   slipState <= slip1;
                default: slipState <= average;
            endcase
        end
    end

    //**************************************************
    // Lock counter
    //**************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            slip        <= 1'b0;
            bitsyncLock <= 1'b0;
            lockCounter <= '0;
        end else if (sym2xEn) begin
            slip <= 1'b0;
            if (slipState == test) begin
                if (slipLow) begin
                    // Bottom sits at minus lockCount minus one
                    if (lockCounter == ~lockCount) begin
                        bitsyncLock <= 1'b0;
                        lockCounter <= '0;
                        slip        <= 1'b1;
                    end else begin
                        lockCounter <= lockCounter - 1'b1;
                    end
                end else if (lockCounter == lockCount) begin
                    bitsyncLock <= 1'b1;
                    lockCounter <= '0;
                end else begin
                    lockCounter <= lockCounter + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/loopFilter.sv
// Sample rate loop filter
`timescale 1ns/1ps
`include "bitsync_defs.svh"

module loopFilter import bitsyncPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       errorEn,
    input  wideErrorT  timingError,
    input  freqT       centerFreq,
    input  logic [4:0] propShift,
    input  logic [4:0] intShift,
    output freqT       sampleFreq
);

    localparam int dropBits = $bits(wideErrorT) - `ERROR_WIDTH;

    logic signed [`ERROR_WIDTH-1:0] loopError;
    logic signed [`ERROR_WIDTH-1:0] heldError;
    logic signed [`FREQ_WIDTH-1:0]  loopErrorWide;
    logic signed [`FREQ_WIDTH-1:0]  heldErrorWide;
    logic signed [`FREQ_WIDTH-1:0]  intTerm;
    logic signed [`FREQ_WIDTH-1:0]  propTerm;
    logic signed [`FREQ_WIDTH-1:0]  integrator;

    // Round off the low bits of the I+Q error
    assign loopError = timingError[$bits(wideErrorT)-1 -: `ERROR_WIDTH]
                     + timingError[dropBits-1];

    assign loopErrorWide = `FREQ_WIDTH'(loopError);
    assign heldErrorWide = `FREQ_WIDTH'(heldError);

    assign intTerm  = (intShift == shiftOff) ? '0 : loopErrorWide <<< intShift;
    assign propTerm = (propShift == shiftOff) ? '0 : heldErrorWide <<< propShift;

    always_ff @(posedge clk) begin
        if (reset) begin
            integrator <= '0;
            heldError  <= '0;
        end else if (errorEn) begin
            integrator <= integrator + intTerm;
            heldError  <= loopError;
        end
    end

    assign sampleFreq = centerFreq + integrator + propTerm;

endmodule

// File: logic/sampleSummer.sv
// Two-sample matched filter
`timescale 1ns/1ps

module sampleSummer import bitsyncPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   sym2xEn,
    input  logic   useSummer,
    input  sampleT i,
    input  sampleT q,
    output sampleT filtI,
    output sampleT filtQ
);

    sampleT iDelay;
    sampleT qDelay;
    logic signed [$bits(sampleT):0] iSum;
    logic signed [$bits(sampleT):0] qSum;

    // One bit of growth, dropped again by the halving
    assign iSum = iDelay + i;
    assign qSum = qDelay + q;

    always_ff @(posedge clk) begin
        if (reset) begin
            iDelay <= '0;
            qDelay <= '0;
            filtI  <= '0;
            filtQ  <= '0;
        end else if (sym2xEn) begin
            iDelay <= i;
            qDelay <= q;
            if (useSummer) begin
                filtI <= iSum[$bits(sampleT):1];
                filtQ <= qSum[$bits(sampleT):1];
            end else begin
                filtI <= i;
                filtQ <= q;
            end
        end
    end

endmodule

// File: logic/timingErrorDetector.sv
// Sign-based timing error detector
`timescale 1ns/1ps

module timingErrorDetector import bitsyncPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      sym2xEn,
    input  logic      slip,
    input  sampleT    filtI,
    input  sampleT    filtQ,
    output logic      errorEn,
    output logic      transition,
    output logic      bitDataI,
    output logic      bitDataQ,
    output wideErrorT timingError,
    output sampleT    absError,
    output sampleT    absSlipError,
    output sampleT    symDataI,
    output sampleT    symDataQ
);

    localparam int sampleMsb = $bits(sampleT) - 1;

    tedStateT tedState;
    logic     slipped;
    sampleT   histI [3];
    sampleT   histQ [3];
    sampleT   errorI;
    sampleT   errorQ;
    sampleT   slipError;

    // Index 2 is the early on-time sample, 1 the off-time, 0 the late
    always_ff @(posedge clk) begin
        if (sym2xEn) begin
            histI[0] <= filtI;
            histI[1] <= histI[0];
            histI[2] <= histI[1];
            histQ[0] <= filtQ;
            histQ[1] <= histQ[0];
            histQ[2] <= histQ[1];
        end
    end

    //**************************************************
    // On-time / off-time state and rail errors
    //**************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            tedState   <= onTime;
            slipped    <= 1'b0;
            transition <= 1'b0;
            errorI     <= '0;
            errorQ     <= '0;
            slipError  <= '0;
        end else if (sym2xEn) begin
            case (tedState)
                onTime: begin
                    // Hold one extra half symbol to slip the phase
                    tedState <= (slip && !slipped) ? onTime : offTime;
                    slipped  <= slip;
                end
                default: begin
                    tedState <= onTime;
                    if (histI[2][sampleMsb] != histI[0][sampleMsb]) begin
                        transition <= 1'b1;
                        // Sign bit high to low
                        if (histI[2][sampleMsb]) begin
                            errorI    <= histI[1];
                            slipError <= histI[0];
                        end else begin
                            errorI    <= -histI[1];
                            slipError <= histI[2];
                        end
                    end else begin
                        transition <= 1'b0;
                        errorI     <= '0;
                    end
                    // Q only adds to the loop error
                    if (histQ[2][sampleMsb] != histQ[0][sampleMsb]) begin
                        errorQ <= histQ[2][sampleMsb] ? histQ[1] : -histQ[1];
                    end else begin
                        errorQ <= '0;
                    end
                end
            endcase
        end
    end

    assign errorEn      = sym2xEn && (tedState == onTime);
    assign timingError  = wideErrorT'(errorI) + wideErrorT'(errorQ);
    assign absError     = errorI[sampleMsb] ? -errorI : errorI;
    assign absSlipError = slipError[sampleMsb] ? -slipError : slipError;

    // Recovered symbols from the middle sample
    always_ff @(posedge clk) begin
        if (errorEn) begin
            bitDataI <= histI[1][sampleMsb];
            bitDataQ <= histQ[1][sampleMsb];
            symDataI <= histI[1];
            symDataQ <= histQ[1];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the bit synchronizer simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f bitsync.f \
    --top-module bitsyncTb -o bitsyncSim

out=$(./obj_dir/bitsyncSim)
echo "$out"

# Fails the script when the pass message is missing
echo "$out" | grep -qF '*** TEST PASSED ***'
